/* sources.f */
+incdir+design
design/fetch_pkg.sv
design/pc_gen.sv
design/icache.sv
design/rd_arbiter.sv
design/axi_rd_master.sv
design/fetch_stage.sv
bench/axi_mem_model.sv
bench/tb_fetch.sv

/* Makefile */
TOP := tb_fetch

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module fetch_stage

obj_dir/V$(TOP): sources.f design/*.sv design/*.svh bench/*.sv
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint sim clean

/* bench/tb_fetch.sv */
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module tb_fetch import fetch_pkg::*; ();

  localparam logic [31:0] PATTERN   = 32'h5a3c_96e1;
  localparam logic [31:0] NOP       = 32'h0000_0013; // bubble inst
  localparam logic [63:0] DATA_ADDR = 64'h0000_0000_1000_0008; // uncached word
  // ~15 bursts of at most ~25 cycles plus ~150 fetch cycles, wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic        clk;
  logic        rst_n;
  logic        id_ready;
  logic        redirect;
  logic [63:0] redirect_pc;
  fetch_out_t  fetch_out;
  rd_req_t     data_req;
  rd_beat_t    data_beat;
  axi_ar_t     ar;
  logic        ar_ready;
  axi_r_t      r_bus;
  logic        r_ready;

  logic [63:0] exp_pc;       // next pc decode should take
  logic [63:0] last_ar_addr; // addr of the latest ar handshake
  logic        data_pend;    // data read seen, beat not back yet
  logic        data_ar_due;  // next ar must be the data read
  logic        burst_open;   // ar accepted, last r beat not taken yet
  logic        hit_run;      // window where every cycle must hit
  int          consumed;
  int          data_reads;
  int          err_cnt = 0;
  int          cycle_cnt;

  fetch_stage i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ready_i   (id_ready),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc),
    .fetch_o      (fetch_out),
    .data_req_i   (data_req),
    .data_beat_o  (data_beat),
    .ar_o         (ar),
    .ar_ready_i   (ar_ready),
    .r_i          (r_bus),
    .r_ready_o    (r_ready)
  );

  axi_mem_model #(.PATTERN(PATTERN)) u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .ar_i      (ar),
    .ar_ready_o(ar_ready),
    .r_o       (r_bus),
    .r_ready_i (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  function automatic logic [31:0] inst_of(input logic [63:0] pc);
    inst_of = pc[31:0] ^ pc[63:32] ^ PATTERN; // same rule as the memory
  endfunction

  function automatic logic [63:0] word_of(input logic [63:0] addr);
    word_of = {inst_of(addr + 64'd4), inst_of(addr)};
  endfunction

  task automatic note_error(input string msg);
    err_cnt++;
    $display("** Error at %0d ns: %s", $time, msg);
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s finished, %0d errors so far", num, name, err_cnt);
  endtask

  // reference model of program order, updated on what decode takes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc       <= `RESET_PC;
      last_ar_addr <= '0;
      data_pend    <= 1'b0;
      data_ar_due  <= 1'b0;
      burst_open   <= 1'b0;
      consumed     <= 0;
      data_reads   <= 0;
    end else begin
      if (redirect) begin
        exp_pc <= redirect_pc;
      end else if (fetch_out.valid && id_ready) begin
        exp_pc <= exp_pc + 64'd4;
      end
      if (fetch_out.valid && id_ready) begin
        consumed <= consumed + 1;
      end
      if (data_beat.valid) begin
        data_pend  <= 1'b0;
        data_reads <= data_reads + 1;
      end else if (data_req.valid) begin
        data_pend <= 1'b1;
      end
      if (ar.valid && ar_ready) begin
        last_ar_addr <= ar.addr;
        data_ar_due  <= 1'b0;
      end else if (data_req.valid && !data_pend && !data_beat.valid) begin
        data_ar_due <= 1'b1; // first edge with the data read up
      end
      if (ar.valid && ar_ready) begin
        burst_open <= 1'b1;
      end else if (r_bus.valid && r_ready && r_bus.last) begin
        burst_open <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    fetch_out.valid |-> fetch_out.pc == exp_pc)
    else note_error($sformatf("fetch pc %h, expected %h", fetch_out.pc, exp_pc));

  assert property (@(posedge clk) disable iff (!rst_n)
    fetch_out.inst == (fetch_out.valid ? inst_of(fetch_out.pc) : NOP))
    else note_error($sformatf("inst %h wrong for pc %h", fetch_out.inst, fetch_out.pc));

  assert property (@(posedge clk) disable iff (!rst_n)
    hit_run |-> fetch_out.valid && !ar.valid)
    else note_error("bubble or ar valid during a cached line pass");

  // held output must not move while decode is stalled
  assert property (@(posedge clk) disable iff (!rst_n)
    (!$past(id_ready) && !$past(redirect)) |-> fetch_out == $past(fetch_out))
    else note_error("fetch output changed during stall");

  assert property (@(posedge clk) disable iff (!rst_n)
    data_beat.valid |-> data_pend && data_beat.last && data_beat.id == `ID_DATA &&
                        data_beat.data == word_of(DATA_ADDR))
    else note_error($sformatf("data beat id %0d data %h, expected %h", data_beat.id,
                              data_beat.data, word_of(DATA_ADDR)));

  assert property (@(posedge clk) disable iff (!rst_n)
    (data_ar_due && ar.valid) |-> ar.id == `ID_DATA && ar.addr == DATA_ADDR && ar.len == 8'd0)
    else note_error($sformatf("ar id %0d addr %h, expected the data read", ar.id, ar.addr));

  assert property (@(posedge clk) disable iff (!rst_n)
    (ar.valid && ar.id == `ID_REFILL) |-> ar.addr[4:0] == 5'd0 &&
                                          ar.len == 8'(`LINE_WORDS - 1))
    else note_error($sformatf("refill ar addr %h len %0d", ar.addr, ar.len));

  // every burst is incr with 8-byte beats
  assert property (@(posedge clk) disable iff (!rst_n)
    ar.valid |-> ar.size == 3'd3 && ar.burst == 2'b01)
    else note_error($sformatf("ar size %0d burst %0d, expected 8-byte incr",
                              ar.size, ar.burst));

  // one burst at a time, r ready exactly while it is open
  assert property (@(posedge clk) disable iff (!rst_n)
    r_ready == burst_open && !(burst_open && ar.valid))
    else note_error($sformatf("r ready %b ar valid %b with burst open %b",
                              r_ready, ar.valid, burst_open));

  task automatic next_cycle();
    @(posedge clk);
    #2; // inputs move just after the edge
  endtask

  task automatic redirect_to(input logic [63:0] target);
    redirect    = 1'b1;
    redirect_pc = target;
    next_cycle();
    redirect    = 1'b0;
  endtask

  task automatic wait_fetch(input logic [63:0] pc);
    while (!(fetch_out.valid && fetch_out.pc == pc)) next_cycle();
  endtask

  task automatic run_insts(input int n);
    int start;
    start = consumed;
    while (consumed < start + n) next_cycle();
  endtask

  // refill of this line has passed ar and is returning beats
  task automatic wait_refill_of(input logic [63:0] line);
    while (!(r_ready && last_ar_addr == line)) next_cycle();
  endtask

  task automatic raise_data_read();
    data_req.valid = 1'b1;
    data_req.addr  = DATA_ADDR;
    data_req.len   = 8'd0; // single beat
  endtask

  task automatic take_data_beat();
    while (!data_beat.valid) next_cycle();
    data_req = '0; // dropped before the edge that takes the beat
  endtask

  initial begin
    rst_n       = 1'b0;
    id_ready    = 1'b1;
    redirect    = 1'b0;
    redirect_pc = '0;
    data_req    = '0;
    hit_run     = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    run_insts(20); // three lines from reset
    report_test(1, "sequential fetch");

    redirect_to(`RESET_PC);
    wait_fetch(`RESET_PC);
    hit_run = 1'b1; // whole line 0 again, all hits
    repeat (8) next_cycle();
    hit_run = 1'b0;
    report_test(2, "hit timing");

    redirect_to(`RESET_PC + 64'h44);
    wait_fetch(`RESET_PC + 64'h44);
    run_insts(3);
    redirect_to(`RESET_PC + 64'h400); // cold line
    wait_refill_of(`RESET_PC + 64'h400);
    redirect_to(`RESET_PC + 64'h104); // in the middle of that refill
    wait_fetch(`RESET_PC + 64'h104);
    run_insts(4);
    report_test(3, "redirect");

    run_insts(2);
    id_ready = 1'b0;
    repeat (6) next_cycle();
    id_ready = 1'b1;
    run_insts(2);
    redirect_to(`RESET_PC + 64'h600);
    id_ready = 1'b0; // refill lands while stalled
    wait_refill_of(`RESET_PC + 64'h600);
    while (r_ready) next_cycle();
    repeat (3) next_cycle();
    id_ready = 1'b1;
    wait_fetch(`RESET_PC + 64'h600);
    report_test(4, "stall");

    redirect_to(`RESET_PC + 64'h800);
    wait_refill_of(`RESET_PC + 64'h800);
    raise_data_read(); // waits behind the refill in flight
    redirect_to(`RESET_PC + 64'ha00); // its refill queues behind the data read
    take_data_beat();
    next_cycle();
    raise_data_read(); // refill of 0xa00 still pending, data must win
    take_data_beat();
    wait_fetch(`RESET_PC + 64'ha00);
    run_insts(4);
    report_test(5, "data port");

    $display("tests 5, instructions %0d, data reads %0d, errors %0d",
             consumed, data_reads, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* bench/axi_mem_model.sv */
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module axi_mem_model import fetch_pkg::*; #(
  parameter logic [31:0] PATTERN = 32'h0 // xor mask on every data half
) (
  input  logic    clk,
  input  logic    rst_n,
  input  axi_ar_t ar_i,
  output logic    ar_ready_o,
  output axi_r_t  r_o,
  input  logic    r_ready_i
);

  logic [31:0]        rnd_q;     // xorshift state
  logic               busy_q;    // one burst at a time
  logic [`ADDR_W-1:0] addr_q;    // address of the beat on offer
  logic [7:0]         left_q;    // beats left after this one
  logic [3:0]         id_q;
  logic               r_valid_q;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    xorshift = y ^ (y << 5);
  endfunction

  // each 32-bit half is derived from its own byte address
  function automatic logic [31:0] half_at(input logic [`ADDR_W-1:0] a);
    half_at = a[31:0] ^ a[63:32] ^ PATTERN;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rnd_q      <= 32'd12; // fixed seed
      busy_q     <= 1'b0;
      addr_q     <= '0;
      left_q     <= '0;
      id_q       <= '0;
      r_valid_q  <= 1'b0;
      ar_ready_o <= 1'b0;
    end else begin
      rnd_q <= xorshift(rnd_q);
      if (!busy_q) begin
        if (ar_i.valid && ar_ready_o) begin
          busy_q     <= 1'b1;
          ar_ready_o <= 1'b0; // no second ar while bursting
          addr_q     <= ar_i.addr;
          left_q     <= ar_i.len;
          id_q       <= ar_i.id;
        end else begin
          ar_ready_o <= rnd_q[0] | rnd_q[1]; // ready about 3 cycles in 4
        end
      end else if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0; // at least one idle cycle between beats
        addr_q    <= addr_q + 64'd8;
        left_q    <= left_q - 8'd1;
        if (left_q == 8'd0) begin
          busy_q <= 1'b0;
        end
      end else if (!r_valid_q) begin
        r_valid_q <= rnd_q[3] | rnd_q[4]; // random gap before next beat
      end
    end
  end

  assign r_o.valid = r_valid_q;
  assign r_o.id    = id_q;
  assign r_o.data  = {half_at(addr_q + 64'd4), half_at(addr_q)}; // little endian
  assign r_o.resp  = 2'b00; // always okay
  assign r_o.last  = (left_q == 8'd0);

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        id_ready_i,
  input  logic        redirect_i,
  input  logic [63:0] redirect_pc_i,
  output fetch_out_t  fetch_o,       // to decode
  input  rd_req_t     data_req_i,    // uncached read from mem stage
  output rd_beat_t    data_beat_o,
  output axi_ar_t     ar_o,
  input  logic        ar_ready_i,
  input  axi_r_t      r_i,
  output logic        r_ready_o
);

  fetch_req_t fetch_req;
  logic       cache_accept;
  rd_req_t    refill_req;
  rd_beat_t   refill_beat;
  rd_req_t    bus_req;
  logic [3:0] bus_id;
  rd_beat_t   bus_beat;

  pc_gen u_pc_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ready_i   (id_ready_i),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .accept_i     (cache_accept),
    .req_o        (fetch_req)
  );

  icache u_icache (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (fetch_req),
    .flush_i      (redirect_i), // redirect kills older fetches
    .accept_o     (cache_accept),
    .out_o        (fetch_o),
    .id_ready_i   (id_ready_i),
    .refill_req_o (refill_req),
    .refill_beat_i(refill_beat)
  );

  rd_arbiter u_rd_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .refill_req_i (refill_req),
    .data_req_i   (data_req_i),
    .refill_beat_o(refill_beat),
    .data_beat_o  (data_beat_o),
    .bus_req_o    (bus_req),
    .bus_id_o     (bus_id),
    .bus_beat_i   (bus_beat)
  );

  axi_rd_master u_axi_rd_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (bus_req),
    .id_i      (bus_id),
    .beat_o    (bus_beat),
    .ar_o      (ar_o),
    .ar_ready_i(ar_ready_i),
    .r_i       (r_i),
    .r_ready_o (r_ready_o)
  );

endmodule

/* design/axi_rd_master.sv */
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module axi_rd_master import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  rd_req_t    req_i,      // granted request from the arbiter
  input  logic [3:0] id_i,       // id of the granted port
  output rd_beat_t   beat_o,
  output axi_ar_t    ar_o,
  input  logic       ar_ready_i,
  input  axi_r_t     r_i,
  output logic       r_ready_o
);

  localparam logic [2:0] AXI_SIZE_8B    = 3'b011; // 8 bytes per beat
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef enum logic [1:0] {M_IDLE, M_ADDR, M_DATA} mstate_t;

  mstate_t            state_q;
  logic [`ADDR_W-1:0] addr_q;
  logic [7:0]         len_q;
  logic [3:0]         id_q;
  logic               take_req;
  logic               ar_hs;
  logic               r_hs;

  assign take_req = (state_q == M_IDLE) & req_i.valid;
  assign ar_hs    = ar_o.valid & ar_ready_i;
  assign r_hs     = r_i.valid & r_ready_o;

  // request fields frozen at issue, ar stays stable until handshake
  always_ff @(posedge clk) begin
    if (take_req) begin
      addr_q <= req_i.addr;
      len_q  <= req_i.len;
      id_q   <= id_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= M_IDLE;
    end else begin
      case (state_q)
        M_IDLE: if (take_req) state_q <= M_ADDR;
        M_ADDR: if (ar_hs) state_q <= M_DATA; // valid drops right after handshake
        M_DATA: if (r_hs && r_i.last) state_q <= M_IDLE;
        default: state_q <= M_IDLE;
      endcase
    end
  end

  assign ar_o.valid = (state_q == M_ADDR);
  assign ar_o.id    = id_q;
  assign ar_o.addr  = addr_q;
  assign ar_o.len   = len_q;
  assign ar_o.size  = AXI_SIZE_8B;
  assign ar_o.burst = AXI_BURST_INCR;

  assign r_ready_o = (state_q == M_DATA); // always ready while a burst is open

  // every accepted r beat goes straight out, id from the slave
  assign beat_o.valid = r_hs;
  assign beat_o.id    = r_i.id;
  assign beat_o.data  = r_i.data;
  assign beat_o.last  = r_i.last;

endmodule

/* design/rd_arbiter.sv */
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module rd_arbiter import fetch_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  rd_req_t  refill_req_i,  // icache line refill
  input  rd_req_t  data_req_i,    // uncached load, single beat
  output rd_beat_t refill_beat_o,
  output rd_beat_t data_beat_o,   // no back-pressure, mem stage must take it
  output rd_req_t  bus_req_o,
  output logic [3:0] bus_id_o,
  input  rd_beat_t bus_beat_i
);

  logic busy_q; // a burst owns the master until its last beat
  logic any_req;
  logic pick_data;

  assign any_req   = refill_req_i.valid | data_req_i.valid;
  assign pick_data = data_req_i.valid; // fixed priority, data port wins

  always_comb begin
    bus_req_o       = pick_data ? data_req_i : refill_req_i;
    bus_req_o.valid = ~busy_q & any_req; // master is idle whenever not busy
  end

  assign bus_id_o = pick_data ? `ID_DATA : `ID_REFILL;

  // grant lock, set on issue, dropped on last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (bus_beat_i.valid && bus_beat_i.last) begin
      busy_q <= 1'b0; // next grant the cycle after last
    end else if (bus_req_o.valid) begin
      busy_q <= 1'b1;
    end
  end

  // steer beats back by their id
  always_comb begin
    refill_beat_o       = bus_beat_i;
    refill_beat_o.valid = bus_beat_i.valid & (bus_beat_i.id == `ID_REFILL);
    data_beat_o         = bus_beat_i;
    data_beat_o.valid   = bus_beat_i.valid & (bus_beat_i.id == `ID_DATA);
  end

endmodule

/* design/icache.sv */
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module icache import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  fetch_req_t req_i,
  input  logic       flush_i,       // redirect, kill anything older
  output logic       accept_o,      // current pc delivered this cycle
  output fetch_out_t out_o,
  input  logic       id_ready_i,
  output rd_req_t    refill_req_o,
  input  rd_beat_t   refill_beat_i
);

  localparam int WORD_W = $clog2(`LINE_WORDS);
  localparam int IDX_W  = $clog2(`CACHE_LINES);
  localparam int OFF_W  = WORD_W + 3; // byte offset inside a line
  localparam int TAG_W  = `ADDR_W - OFF_W - IDX_W;
  localparam logic [31:0] NOP = 32'h0000_0013; // addi x0,x0,0

  typedef enum logic {S_IDLE, S_REFILL} state_t;

  state_t                 state_q;
  logic [63:0]            data_mem [`CACHE_LINES*`LINE_WORDS];
  logic [TAG_W-1:0]       tag_mem [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid_q;
  logic [`ADDR_W-1:0]     miss_pc_q;
  logic [WORD_W-1:0]      beat_cnt_q;
  logic                   req_pend_q; // refill request still waiting for beat 0
  logic                   drop_q;     // redirect seen, throw away missed inst
  fetch_out_t             out_q;
  fetch_out_t             out_d;

  logic [IDX_W-1:0]  req_idx;
  logic [WORD_W-1:0] req_word;
  logic [TAG_W-1:0]  req_tag;
  logic [IDX_W-1:0]  miss_idx;
  logic [WORD_W-1:0] miss_word;
  logic [TAG_W-1:0]  miss_tag;
  logic [63:0]       hit_word;
  logic [63:0]       crit_word;
  logic              hit;
  logic              miss;
  logic              refill_beat;
  logic              refill_last;

  // pc bit 2 picks the 32-bit half of the 64-bit word
  function automatic logic [31:0] pick_half(input logic [63:0] word, input logic upper);
    pick_half = upper ? word[63:32] : word[31:0];
  endfunction

  assign req_idx   = req_i.pc[OFF_W +: IDX_W];
  assign req_word  = req_i.pc[3 +: WORD_W];
  assign req_tag   = req_i.pc[`ADDR_W-1 -: TAG_W];
  assign miss_idx  = miss_pc_q[OFF_W +: IDX_W];
  assign miss_word = miss_pc_q[3 +: WORD_W];
  assign miss_tag  = miss_pc_q[`ADDR_W-1 -: TAG_W];

  assign hit_word = data_mem[{req_idx, req_word}];
  assign hit      = req_i.valid & valid_q[req_idx] & (tag_mem[req_idx] == req_tag);
  assign miss     = (state_q == S_IDLE) & req_i.valid & ~hit & ~flush_i;

  assign refill_beat = (state_q == S_REFILL) & refill_beat_i.valid;
  assign refill_last = refill_beat & refill_beat_i.last;

  // missed word is either already in the array or on the bus right now
  assign crit_word = (beat_cnt_q == miss_word) ? refill_beat_i.data
                                               : data_mem[{miss_idx, miss_word}];

  always_comb begin
    if (state_q == S_IDLE) begin
      out_d.valid = hit;
      out_d.pc    = req_i.pc;
      out_d.inst  = hit ? pick_half(hit_word, req_i.pc[2]) : NOP;
    end else begin
      // deliver straight off the last beat, saves a lookup cycle
      out_d.valid = refill_last & ~drop_q;
      out_d.pc    = miss_pc_q;
      out_d.inst  = out_d.valid ? pick_half(crit_word, miss_pc_q[2]) : NOP;
    end
  end

  assign accept_o = (state_q == S_IDLE) ? hit : (refill_last & ~drop_q);

  // arrays and miss address, no reset needed
  always_ff @(posedge clk) begin
    if (miss) begin
      miss_pc_q <= req_i.pc;
    end
    if (refill_beat) begin
      data_mem[{miss_idx, beat_cnt_q}] <= refill_beat_i.data; // beats arrive in order
      if (refill_beat_i.last) begin
        tag_mem[miss_idx] <= miss_tag;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= S_IDLE;
      valid_q    <= '0;
      beat_cnt_q <= '0;
      req_pend_q <= 1'b0;
      drop_q     <= 1'b0;
      out_q      <= '{valid: 1'b0, pc: '0, inst: NOP};
    end else begin
      case (state_q)
        S_IDLE: begin
          if (miss) begin
            state_q          <= S_REFILL;
            valid_q[req_idx] <= 1'b0; // line is about to be overwritten
            beat_cnt_q       <= '0;
            req_pend_q       <= 1'b1;
            drop_q           <= 1'b0;
          end
        end
        S_REFILL: begin
          if (flush_i) begin
            drop_q <= 1'b1; // line still fills, inst is lost
          end
          if (refill_beat) begin
            req_pend_q <= 1'b0;
            beat_cnt_q <= beat_cnt_q + WORD_W'(1);
          end
          if (refill_last) begin
            valid_q[miss_idx] <= 1'b1;
            state_q           <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase

      if (flush_i) begin
        out_q.valid <= 1'b0; // older pc never reaches decode
        out_q.inst  <= NOP;
      end else if (id_ready_i) begin
        out_q <= out_d; // decode stalled means hold
      end
    end
  end

  assign out_o = out_q;

  // aligned line address, full line burst
  assign refill_req_o.valid = req_pend_q;
  assign refill_req_o.addr  = {miss_pc_q[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign refill_req_o.len   = 8'(`LINE_WORDS - 1);

endmodule

/* design/pc_gen.sv */
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module pc_gen import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        id_ready_i,    // decode can take an instruction
  input  logic        redirect_i,    // branch / jump taken
  input  logic [63:0] redirect_pc_i, // target of redirect
  input  logic        accept_i,      // icache took the current pc
  output fetch_req_t  req_o
);

  logic [`ADDR_W-1:0] pc_q;
  logic [`ADDR_W-1:0] pc_d;
  logic               req_vld_q; // low only while in reset
  logic               advance;

  // step only when the cache delivered and decode moves on
  assign advance = req_vld_q & accept_i & id_ready_i;

  always_comb begin
    pc_d = pc_q; // default is hold, covers stall and miss
    if (redirect_i) begin
      pc_d = redirect_pc_i; // redirect beats everything
    end else if (advance) begin
      pc_d = pc_q + `ADDR_W'(4); // next sequential inst
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q      <= `RESET_PC;
      req_vld_q <= 1'b0;
    end else begin
      pc_q      <= pc_d;
      req_vld_q <= 1'b1; // fetch runs every cycle from now on
    end
  end

  // the pc register itself is the fetch request
  assign req_o.valid = req_vld_q;
  assign req_o.pc    = pc_q;

endmodule

/* design/fetch_pkg.sv */
`include "fetch_cfg.svh"

package fetch_pkg;

  // pc_gen to icache, one fetch address per cycle
  typedef struct packed {
    logic valid;
    logic [`ADDR_W-1:0] pc;
  } fetch_req_t;

  // icache to decode, inst is nop while valid low
  typedef struct packed {
    logic valid;
    logic [`ADDR_W-1:0] pc;
    logic [31:0] inst;
  } fetch_out_t;

  // read request level, held until first beat comes back
  typedef struct packed {
    logic valid;
    logic [`ADDR_W-1:0] addr;
    logic [7:0] len; // beats minus one
  } rd_req_t;

  // one returned read beat, tagged with its axi id
  typedef struct packed {
    logic valid;
    logic [3:0] id;
    logic [63:0] data;
    logic last;
  } rd_beat_t;

  typedef struct packed {
    logic valid;
    logic [3:0] id;
    logic [`ADDR_W-1:0] addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;

  typedef struct packed {
    logic valid;
    logic [3:0] id;
    logic [63:0] data;
    logic [1:0] resp;
    logic last;
  } axi_r_t;

endpackage

/* design/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first fetch address out of reset, start of dram
`define RESET_PC 64'h0000_0000_8000_0000

// virtual address width of the core
`define ADDR_W 64

// icache geometry
// one line is LINE_WORDS x 64-bit words, so 32 bytes
`define LINE_WORDS 4
`define CACHE_LINES 16 // direct mapped, one way

// axi read ids
// refill and uncached data share the single read master
`define ID_REFILL 4'd0 // icache line refill
`define ID_DATA 4'd1 // uncached load from mem stage

`endif
